/* alu.sv */
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic [xlen-1:0] imm32,
    input  logic            aluSrc,
    input  logic [1:0]      aluOp,
    input  instWord         inst,
    output logic [xlen-1:0] aluResult,
    output logic            zero
);

    logic [2:0]      aluCtl;
    logic [xlen-1:0] operandB;

    // ----------------------------------------
    // ALU control
    // ----------------------------------------
    always_comb begin
        case (aluOp)
            aluAdd:  aluCtl = ctlAdd;
            aluSub:  aluCtl = ctlSub;
            aluPass: aluCtl = ctlPassB;
            default: begin
                // funct3 picks the op
                case (inst.rType.funct3)
                    // funct7 only means sub for R type, addi keeps imm bits there
                    f3AddSub: aluCtl = ((inst.rType.opcode == opR) &&
                                        (inst.rType.funct7 == f7Sub)) ? ctlSub : ctlAdd;
                    f3Slt:    aluCtl = ctlSlt;
                    f3Or:     aluCtl = ctlOr;
                    f3And:    aluCtl = ctlAnd;
                    default:  aluCtl = ctlAdd;
                endcase
            end
        endcase
    end

    // Register or immediate second operand
    assign operandB = aluSrc ? imm32 : rdata2;

    // ----------------------------------------
    // Arithmetic
    // ----------------------------------------
    always_comb begin
        case (aluCtl)
            ctlSub:   aluResult = rdata1 - operandB;
            ctlAnd:   aluResult = rdata1 & operandB;
            ctlOr:    aluResult = rdata1 | operandB;
            // Signed compare, 1 or 0
            ctlSlt:   aluResult = {31'b0, $signed(rdata1) < $signed(operandB)};
            ctlPassB: aluResult = operandB;
            default:  aluResult = rdata1 + operandB;
        endcase
    end

    // Equality for beq
    assign zero = (aluResult == '0);

endmodule

/* cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import rvPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] switches,
    output logic [15:0] led
);

    // ----------------------------------------
    // Datapath nets
    // ----------------------------------------
    instWord         inst;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] imm32;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] readData;
    logic            zero;

    // Control levels
    logic       branch;
    logic       aluSrc;
    logic [1:0] aluOp;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    instFetch fetch (
        .clk    (clk),
        .rst    (rst),
        .branch (branch),
        .imm32  (imm32),
        .inst   (inst),
        // Link value, unused without jal
        .pcPlus4()
    );

    ctrlUnit control (
        .inst     (inst),
        .zero     (zero),
        .branch   (branch),
        .aluSrc   (aluSrc),
        .aluOp    (aluOp),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .regWrite (regWrite)
    );

    regDecode decode (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .regWrite  (regWrite),
        .memToReg  (memToReg),
        .aluResult (aluResult),
        .readData  (readData),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm32     (imm32)
    );

    alu execute (
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm32     (imm32),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .inst      (inst),
        .aluResult (aluResult),
        .zero      (zero)
    );

    // ALU result is the load/store address
    memOrIo memIo (
        .clk       (clk),
        .rst       (rst),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addr      (aluResult),
        .writeData (rdata2),
        .switches  (switches),
        .readData  (readData),
        .led       (led)
    );

endmodule

/* ctrlUnit.sv */
`timescale 1ns/1ps

module ctrlUnit import rvPkg::*; (
    input  instWord    inst,
    input  logic       zero,
    output logic       branch,
    output logic       aluSrc,
    output logic [1:0] aluOp,
    output logic       memRead,
    output logic       memWrite,
    output logic       memToReg,
    output logic       regWrite
);

    // Instruction is a beq, zero not yet applied
    logic isBeq;

    // ----------------------------------------
    // Main decoder
    // ----------------------------------------
    always_comb begin
        // All inactive, unknown opcodes fall through as no-ops
        isBeq    = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = aluAdd;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        case (inst.rType.opcode)
            opR: begin
                aluOp    = aluFunct;
                regWrite = 1'b1;
            end
            opI: begin
                // Immediate operand, funct3 picks the op
                aluSrc   = 1'b1;
                aluOp    = aluFunct;
                regWrite = 1'b1;
            end
            opLoad: begin
                // Address = rs1 + imm
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opBranch: begin
                // Compare by subtraction, zero means equal
                aluOp = aluSub;
                isBeq = (inst.bType.funct3 == f3Beq);
            end
            opLui: begin
                // Shifted immediate passed through to rd
                aluSrc   = 1'b1;
                aluOp    = aluPass;
                regWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Kept apart so zero feeds only this gate
    assign branch = isBeq & zero;

endmodule

/* instFetch.sv */
`timescale 1ns/1ps

module instFetch import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            branch,
    input  logic [xlen-1:0] imm32,
    output instWord         inst,
    output logic [xlen-1:0] pcPlus4
);

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcNext;

    // Word index into the ROM, byte offset dropped
    logic [$clog2(romDepth)-1:0] romIdx;

    // Instruction ROM, contents from prog.hex
    logic [xlen-1:0] rom [romDepth];

    initial begin
        $readmemh("prog.hex", rom);
    end

    // Sequential successor
    assign pcPlus4 = pc + 32'd4;

    // Taken beq jumps relative to the current pc
    assign pcNext = branch ? (pc + imm32) : pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // ----------------------------------------
    // Asynchronous ROM read
    // ----------------------------------------
    assign romIdx = pc[$clog2(romDepth)+1:2];

    // Raw word, the union gives the field views downstream
    assign inst = rom[romIdx];

endmodule

/* memOrIo.sv */
`timescale 1ns/1ps

module memOrIo import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] writeData,
    input  logic [15:0]     switches,
    output logic [xlen-1:0] readData,
    output logic [15:0]     led
);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    logic isIo;
    logic isLed;
    logic isSw;

    // Word index for the RAM
    logic [$clog2(ramDepth)-1:0] ramIdx;

    // Data RAM, no reset
    logic [xlen-1:0] ram [ramDepth];

    // Top 1 KB
    assign isIo  = (addr[31:10] == ioBase[31:10]);
    assign isLed = (addr == ledAddr);
    assign isSw  = (addr == swAddr);

    assign ramIdx = addr[$clog2(ramDepth)+1:2];

    // ----------------------------------------
    // Writes on the edge
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (memWrite && !isIo) begin
            ram[ramIdx] <= writeData;
        end
    end

    // LED register, low half of the store data
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (memWrite && isLed) begin
            led <= writeData[15:0];
        end
    end

    // Read mux. Switches zero-extended, other IO reads give 0
    assign readData = !memRead ? '0 :
                      !isIo    ? ram[ramIdx] :
                      isSw     ? {16'b0, switches} : '0;

endmodule

/* prog.hex */
// One 32-bit instruction word per line, ROM word 0 first
// Column 1 is the machine word in hex, the comment is its assembly
06400093  // addi x1, x0, 100
FF900113  // addi x2, x0, -7
C6102023  // sw   x1, -928(x0)    led <= addi result
002081B3  // add  x3, x1, x2
C6302023  // sw   x3, -928(x0)
40110233  // sub  x4, x2, x1
C6402023  // sw   x4, -928(x0)
0020F2B3  // and  x5, x1, x2
C6502023  // sw   x5, -928(x0)
0020E333  // or   x6, x1, x2
C6602023  // sw   x6, -928(x0)
001123B3  // slt  x7, x2, x1      signed, -7 < 100
C6702023  // sw   x7, -928(x0)
12345437  // lui  x8, 0x12345
67840413  // addi x8, x8, 0x678
C6802023  // sw   x8, -928(x0)
04000493  // addi x9, x0, 0x40    RAM address
5A500513  // addi x10, x0, 0x5a5
00A4A023  // sw   x10, 0(x9)
0004A583  // lw   x11, 0(x9)
C6B02023  // sw   x11, -928(x0)
00000463  // beq  x0, x0, +8      taken
C6202023  // sw   x2, -928(x0)    poison, skipped
00208463  // beq  x1, x2, +8      not taken
03300613  // addi x12, x0, 0x33
C6C02023  // sw   x12, -928(x0)
C7002683  // lw   x13, -912(x0)   switches
00368693  // addi x13, x13, 3
C6D02023  // sw   x13, -928(x0)
00000063  // beq  x0, x0, 0       hold

/* regDecode.sv */
`timescale 1ns/1ps

module regDecode import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  instWord         inst,
    input  logic            regWrite,
    input  logic            memToReg,
    input  logic [xlen-1:0] aluResult,
    input  logic [xlen-1:0] readData,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    output logic [xlen-1:0] imm32
);

    // 32 general registers
    logic [xlen-1:0] regs [32];

    // Write-back value
    logic [xlen-1:0] wbData;

    // Register addresses sit at the same bits in every format
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;

    assign rs1 = inst.rType.rs1;
    assign rs2 = inst.rType.rs2;
    assign rd  = inst.rType.rd;

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    // Load data or ALU result
    assign wbData = memToReg ? readData : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != 5'd0)) begin
            // x0 stays hardwired
            regs[rd] <= wbData;
        end
    end

    // Asynchronous read, x0 forced to 0
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // ----------------------------------------
    // Immediate generator
    // ----------------------------------------
    always_comb begin
        case (inst.rType.opcode)
            opI, opLoad: begin
                imm32 = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            end
            opStore: begin
                imm32 = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
            end
            opBranch: begin
                // Byte offset, bit 0 always clear
                imm32 = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                         inst.bType.imm10to5, inst.bType.imm4to1, 1'b0};
            end
            opLui: begin
                imm32 = {inst.uType.imm20, 12'b0};
            end
            default: begin
                // R type and unknown, no immediate
                imm32 = '0;
            end
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpu -f vlog.f -o simCpu

./obj_dir/simCpu > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

/* rvPkg.sv */
package rvPkg;

    // ----------------------------------------
    // Datapath width and memory sizes
    // ----------------------------------------
    localparam int xlen     = 32;
    localparam int romDepth = 256;
    localparam int ramDepth = 256;

    // Opcodes of the supported instruction classes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;

    // funct3 / funct7 values decoded here
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [6:0] f7Sub    = 7'b0100000;

    // ----------------------------------------
    // Control to ALU
    // ----------------------------------------
    // aluOp from the main decoder
    localparam logic [1:0] aluAdd   = 2'b00;
    localparam logic [1:0] aluSub   = 2'b01;
    localparam logic [1:0] aluFunct = 2'b10;
    // Lui passes the immediate straight through
    localparam logic [1:0] aluPass  = 2'b11;

    // Internal ALU operation
    localparam logic [2:0] ctlAdd   = 3'd0;
    localparam logic [2:0] ctlSub   = 3'd1;
    localparam logic [2:0] ctlAnd   = 3'd2;
    localparam logic [2:0] ctlOr    = 3'd3;
    localparam logic [2:0] ctlSlt   = 3'd4;
    localparam logic [2:0] ctlPassB = 3'd5;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    // IO window is the top 1 KB, upper 22 bits compared
    localparam logic [31:0] ioBase  = 32'hFFFF_FC00;
    localparam logic [31:0] ledAddr = 32'hFFFF_FC60;
    localparam logic [31:0] swAddr  = 32'hFFFF_FC70;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeFields;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeFields;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeFields;

    // One 32-bit word, five views
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
        sTypeFields sType;
        bTypeFields bType;
        uTypeFields uType;
    } instWord;

endpackage

/* tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;

    // ----------------------------------------
    // Run limits
    // ----------------------------------------
    localparam int resetCycles  = 4;
    // Words in prog.hex, one retires per cycle
    localparam int progWords    = 30;
    // Quiet window after the last LED value
    localparam int settleCycles = 8;
    // Six cycles per program word plus margin
    localparam int cycleLimit   = resetCycles + 6 * progWords + 16;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] lfsrSeed = 16'd96;
    localparam logic [15:0] lfsrTaps = 16'hB400;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] switches;
    logic [15:0] led;

    // Expected LED sequence, one test name per entry
    logic [15:0] expLed [$];
    string       testName [$];

    logic [15:0] swValue;
    logic [15:0] lastLed = '0;
    int          seen = 0;
    int          cycles = 0;

    // Sequence checks counted by the recorder
    int          seqPass = 0;
    int          seqFail = 0;
    // Reset and count checks counted by the main flow
    int          passCount = 0;
    int          failCount = 0;

    cpuTop u_dut (
        .clk      (clk),
        .rst      (rst),
        .switches (switches),
        .led      (led)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // One LFSR step, the old bit 0 is the bit taken
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ lfsrTaps;
        end
        return next;
    endfunction

    task automatic addExpect(input string name, input logic [15:0] value);
        testName.push_back(name);
        expLed.push_back(value);
    endtask

    // ----------------------------------------
    // LED recorder and sequence check
    // ----------------------------------------
    // led moves on the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (!rst && (led !== lastLed)) begin
            lastLed = led;
            if (seen < expLed.size()) begin
                assert (led == expLed[seen]) begin
                    $display("[PASS] %s: led = 0x%04h", testName[seen], led);
                    seqPass++;
                end else begin
                    $display("[FAIL] %s: expected 0x%04h, actual 0x%04h",
                             testName[seen], expLed[seen], led);
                    seqFail++;
                end
            end else begin
                $display("Error: led changed to 0x%04h after the sequence had ended", led);
                seqFail++;
            end
            seen++;
        end
    end

    // Cycle counter, guards against a stuck program
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the LED sequence did not complete in %0d cycles (%0d of %0d seen)",
                     cycleLimit, seen, expLed.size());
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus and final checks
    // ----------------------------------------
    initial begin
        int          a;
        int          b;
        logic [15:0] lfsr;

        rst      <= 1'b1;
        switches <= '0;

        // Switch word, one LFSR step per bit
        lfsr = lfsrSeed;
        for (int i = 0; i < 16; i++) begin
            swValue[i] = lfsr[0];
            lfsr       = lfsrStep(lfsr);
        end

        // Program operands
        a = 100;
        b = -7;

        // 32-bit two's complement, low half on the LEDs
        addExpect("addi", 16'(a));
        addExpect("add", 16'(a + b));
        addExpect("sub", 16'(b - a));
        addExpect("and", 16'(a & b));
        addExpect("or", 16'(a | b));
        addExpect("slt", (b < a) ? 16'd1 : 16'd0);
        // lui 0x12345 then addi 0x678
        addExpect("lui", 16'((32'h12345 << 12) + 32'h678));
        addExpect("ramRoundTrip", 16'h05A5);
        // Poison store skipped, fall-through store seen
        addExpect("branch", 16'h0033);
        addExpect("switches", swValue + 16'd3);

        // Switches settle while still in reset
        @(posedge clk);
        switches <= swValue;
        repeat (resetCycles - 1) @(posedge clk);
        rst <= 1'b0;

        // LED register cleared by reset
        @(negedge clk);
        assert (led == 16'h0000) begin
            $display("[PASS] resetLed: led = 0x%04h", led);
            passCount++;
        end else begin
            $display("[FAIL] resetLed: expected 0x0000, actual 0x%04h", led);
            failCount++;
        end

        while (seen < expLed.size()) begin
            @(negedge clk);
        end

        // Processor parks on beq, no further changes
        repeat (settleCycles) @(negedge clk);
        assert (seen == expLed.size()) begin
            $display("[PASS] ledCount: %0d changes", seen);
            passCount++;
        end else begin
            $display("[FAIL] ledCount: expected %0d, actual %0d", expLed.size(), seen);
            failCount++;
        end

        $display("Summary: %0d passed, %0d failed",
                 passCount + seqPass, failCount + seqFail);
        if ((failCount + seqFail) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* vlog.f */
rvPkg.sv
instFetch.sv
ctrlUnit.sv
regDecode.sv
alu.sv
memOrIo.sv
cpuTop.sv
tbCpu.sv
